//--- logic/conv_defs.svh
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// tile extents
`define TN 4  // output channels per tile
`define TM 4  // input channels per tile
`define TR 5  // output rows per tile
`define TC 6  // output columns per tile

// kernel window
`define K 3
`define S 2

// datapath widths
`define DIM_W 16
`define AW 32

// register map
`define CFG_DIMS_NM  3'd0  // hi = N, lo = M
`define CFG_DIMS_RC  3'd1  // hi = R, lo = C
`define CFG_IN_BASE  3'd2
`define CFG_WT_BASE  3'd3
`define CFG_OUT_BASE 3'd4

`endif

//--- logic/conv_pkg.sv
`include "conv_defs.svh"

package conv_pkg;

    // one config write word, seen as two dimensions or as one address
    typedef union packed {
        struct packed {
            logic [`DIM_W-1:0] hi;
            logic [`DIM_W-1:0] lo;
        } dims;
        logic [`AW-1:0] addr;
    } cfg_word_u;

    // which buffer a read command fills
    typedef enum logic [1:0] {
        strm_in_fm  = 2'd0,
        strm_weight = 2'd1,
        strm_out_fm = 2'd2
    } stream_e;

endpackage

//--- logic/conv_cfg_regs.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_cfg_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_wr,
    input  logic [2:0]           cfg_addr,
    input  conv_pkg::cfg_word_u  cfg_data,
    output logic [`DIM_W-1:0]    out_n,
    output logic [`DIM_W-1:0]    out_m,
    output logic [`DIM_W-1:0]    in_r,
    output logic [`DIM_W-1:0]    in_c,
    output logic [`DIM_W-1:0]    out_r,
    output logic [`DIM_W-1:0]    out_c,
    output logic [`AW-1:0]       in_base,
    output logic [`AW-1:0]       wt_base,
    output logic [`AW-1:0]       out_base
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_n    <= '0;
            out_m    <= '0;
            in_r     <= '0;
            in_c     <= '0;
            out_r    <= '0;
            out_c    <= '0;
            in_base  <= '0;
            wt_base  <= '0;
            out_base <= '0;
        end else if (cfg_wr) begin
            case (cfg_addr)
                `CFG_DIMS_NM: begin
                    out_n <= cfg_data.dims.hi;
                    out_m <= cfg_data.dims.lo;
                end
                `CFG_DIMS_RC: begin
                    in_r  <= cfg_data.dims.hi;
                    in_c  <= cfg_data.dims.lo;
                    // valid window positions, done once here
                    out_r <= (cfg_data.dims.hi - `K) / `S + 1;
                    out_c <= (cfg_data.dims.lo - `K) / `S + 1;
                end
                `CFG_IN_BASE:  in_base  <= cfg_data.addr;
                `CFG_WT_BASE:  wt_base  <= cfg_data.addr;
                `CFG_OUT_BASE: out_base <= cfg_data.addr;
                default: ;  // unmapped address
            endcase
        end
    end

endmodule

//--- logic/tile_cord_gen.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module tile_cord_gen (
    input  logic              clk,
    input  logic              rst,
    input  logic              tile_done,
    input  logic [`DIM_W-1:0] out_n,
    input  logic [`DIM_W-1:0] out_m,
    input  logic [`DIM_W-1:0] out_r,
    input  logic [`DIM_W-1:0] out_c,
    output logic [`DIM_W-1:0] n_base,
    output logic [`DIM_W-1:0] m_base,
    output logic [`DIM_W-1:0] row_base,
    output logic [`DIM_W-1:0] col_base,
    output logic [`DIM_W-1:0] tile_n_size,
    output logic [`DIM_W-1:0] tile_m_size,
    output logic [`DIM_W-1:0] tile_row_size,
    output logic [`DIM_W-1:0] tile_col_size,
    output logic              last_tile
);

    logic [`DIM_W-1:0] n_rem;
    logic [`DIM_W-1:0] m_rem;
    logic [`DIM_W-1:0] row_rem;
    logic [`DIM_W-1:0] col_rem;
    logic              n_last;
    logic              m_last;
    logic              row_last;
    logic              col_last;

    // clip an edge tile to what is left of the dimension
    function automatic logic [`DIM_W-1:0] clip(input logic [`DIM_W-1:0] rem,
                                              input logic [`DIM_W-1:0] ext);
        clip = (rem < ext) ? rem : ext;
    endfunction

    assign n_rem   = out_n - n_base;
    assign m_rem   = out_m - m_base;
    assign row_rem = out_r - row_base;
    assign col_rem = out_c - col_base;

    assign n_last   = (n_rem <= `DIM_W'(`TN));  // final step on each level
    assign m_last   = (m_rem <= `DIM_W'(`TM));
    assign row_last = (row_rem <= `DIM_W'(`TR));
    assign col_last = (col_rem <= `DIM_W'(`TC));

    assign tile_n_size   = clip(n_rem, `DIM_W'(`TN));
    assign tile_m_size   = clip(m_rem, `DIM_W'(`TM));
    assign tile_row_size = clip(row_rem, `DIM_W'(`TR));
    assign tile_col_size = clip(col_rem, `DIM_W'(`TC));

    assign last_tile = n_last && m_last && row_last && col_last;

    // column innermost, then row, input channel, output channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            n_base   <= '0;
            m_base   <= '0;
            row_base <= '0;
            col_base <= '0;
        end else if (tile_done) begin
            if (!col_last) begin
                col_base <= col_base + `DIM_W'(`TC);
            end else begin
                col_base <= '0;
                if (!row_last) begin
                    row_base <= row_base + `DIM_W'(`TR);
                end else begin
                    row_base <= '0;
                    if (!m_last) begin
                        m_base <= m_base + `DIM_W'(`TM);
                    end else begin
                        m_base <= '0;
                        n_base <= n_last ? '0 : n_base + `DIM_W'(`TN);  // wraps at layer end
                    end
                end
            end
        end
    end

endmodule

//--- logic/tile_xfer_gen.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module tile_xfer_gen (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tile_start,
    input  logic [`DIM_W-1:0]     n_base,
    input  logic [`DIM_W-1:0]     m_base,
    input  logic [`DIM_W-1:0]     row_base,
    input  logic [`DIM_W-1:0]     col_base,
    input  logic [`DIM_W-1:0]     tile_n_size,
    input  logic [`DIM_W-1:0]     tile_m_size,
    input  logic [`DIM_W-1:0]     tile_row_size,
    input  logic [`DIM_W-1:0]     tile_col_size,
    input  logic [`DIM_W-1:0]     in_r,
    input  logic [`DIM_W-1:0]     in_c,
    input  logic [`DIM_W-1:0]     out_m,
    input  logic [`DIM_W-1:0]     out_r,
    input  logic [`DIM_W-1:0]     out_c,
    input  logic [`AW-1:0]        in_base,
    input  logic [`AW-1:0]        wt_base,
    input  logic [`AW-1:0]        out_base,
    output logic                  rd_go,
    output conv_pkg::stream_e     rd_strm,
    output logic [`AW-1:0]        rd_base,
    output logic [`AW-1:0]        rd_len,
    input  logic                  rd_done,
    output logic                  wr_go,
    output logic [`AW-1:0]        wr_base,
    output logic [`AW-1:0]        wr_len,
    input  logic                  wr_done,
    output logic                  comp_start,
    output logic                  first_m,
    input  logic                  comp_done,
    output logic                  tile_done
);

    localparam logic [2:0] PH_IDLE    = 3'd0;
    localparam logic [2:0] PH_IN_FM   = 3'd1;
    localparam logic [2:0] PH_WEIGHT  = 3'd2;
    localparam logic [2:0] PH_OUT_RD  = 3'd3;
    localparam logic [2:0] PH_COMPUTE = 3'd4;
    localparam logic [2:0] PH_OUT_WR  = 3'd5;

    logic [2:0]        phase;
    logic [`DIM_W-1:0] cnt_o;      // channel counter
    logic [`DIM_W-1:0] cnt_i;      // row counter
    logic [`AW-1:0]    line_addr;
    logic [`AW-1:0]    grp_addr;   // first line of current channel
    logic [`DIM_W-1:0] lim_o;
    logic [`DIM_W-1:0] lim_i;
    logic [`AW-1:0]    step_i;
    logic [`AW-1:0]    step_o;
    logic [`AW-1:0]    line_len;
    logic [`AW-1:0]    in_start;
    logic [`AW-1:0]    wt_start;
    logic [`AW-1:0]    out_start;
    logic [`AW-1:0]    in_plane;
    logic [`AW-1:0]    wt_step;
    logic [`AW-1:0]    out_plane;
    logic [`DIM_W-1:0] in_rows;
    logic [`AW-1:0]    in_len;
    logic [`AW-1:0]    wt_len;
    logic              line_done;
    logic              last_i;
    logic              last_o;

    assign first_m = (m_base == '0);

    // per-tile start points and strides, stable for the whole tile
    assign in_start  = in_base + (m_base * in_r + row_base * `S) * in_c + col_base * `S;
    assign wt_start  = wt_base + (n_base * out_m + m_base) * `K * `K;
    assign out_start = out_base + (n_base * out_r + row_base) * out_c + col_base;
    assign in_plane  = in_r * in_c;
    assign wt_step   = out_m * `K * `K;
    assign out_plane = out_r * out_c;
    assign in_rows   = (tile_row_size - 1'b1) * `S + `K;  // includes kernel halo
    assign in_len    = (tile_col_size - 1'b1) * `S + `K;
    assign wt_len    = tile_m_size * `K * `K;

    always_comb begin
        case (phase)
            PH_IN_FM: begin
                lim_o    = tile_m_size;
                lim_i    = in_rows;
                step_i   = in_c;
                step_o   = in_plane;
                line_len = in_len;
            end
            PH_WEIGHT: begin
                lim_o    = tile_n_size;
                lim_i    = 1;          // one block per output channel
                step_i   = '0;
                step_o   = wt_step;
                line_len = wt_len;
            end
            default: begin           // out_fm read and write
                lim_o    = tile_n_size;
                lim_i    = tile_row_size;
                step_i   = out_c;
                step_o   = out_plane;
                line_len = tile_col_size;
            end
        endcase
    end

    always_comb begin
        case (phase)
            PH_IN_FM:  rd_strm = conv_pkg::strm_in_fm;
            PH_WEIGHT: rd_strm = conv_pkg::strm_weight;
            default:   rd_strm = conv_pkg::strm_out_fm;
        endcase
    end

    assign rd_base = line_addr;
    assign wr_base = line_addr;
    assign rd_len  = line_len;
    assign wr_len  = line_len;

    assign line_done = (phase == PH_OUT_WR) ? wr_done :
                       ((phase == PH_IN_FM) || (phase == PH_WEIGHT) ||
                        (phase == PH_OUT_RD)) && rd_done;
    assign last_i = (cnt_i == lim_i - 1'b1);
    assign last_o = (cnt_o == lim_o - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase      <= PH_IDLE;
            cnt_o      <= '0;
            cnt_i      <= '0;
            line_addr  <= '0;
            grp_addr   <= '0;
            rd_go      <= 1'b0;
            wr_go      <= 1'b0;
            comp_start <= 1'b0;
            tile_done  <= 1'b0;
        end else begin
            rd_go      <= 1'b0;  // all go lines are single pulses
            wr_go      <= 1'b0;
            comp_start <= 1'b0;
            tile_done  <= 1'b0;
            case (phase)
                PH_IDLE: if (tile_start) begin
                    phase     <= PH_IN_FM;
                    line_addr <= in_start;
                    grp_addr  <= in_start;
                    rd_go     <= 1'b1;
                end
                PH_COMPUTE: if (comp_done) begin
                    phase     <= PH_OUT_WR;
                    line_addr <= out_start;
                    grp_addr  <= out_start;
                    wr_go     <= 1'b1;
                end
                default: if (line_done) begin
                    if (!last_i || !last_o) begin
                        if (!last_i) begin
                            cnt_i     <= cnt_i + 1'b1;
                            line_addr <= line_addr + step_i;  // next row
                        end else begin
                            cnt_i     <= '0;
                            cnt_o     <= cnt_o + 1'b1;
                            grp_addr  <= grp_addr + step_o;   // next channel
                            line_addr <= grp_addr + step_o;
                        end
                        rd_go <= (phase != PH_OUT_WR);
                        wr_go <= (phase == PH_OUT_WR);
                    end else begin
                        cnt_i <= '0;
                        cnt_o <= '0;
                        case (phase)
                            PH_IN_FM: begin
                                phase     <= PH_WEIGHT;
                                line_addr <= wt_start;
                                grp_addr  <= wt_start;
                                rd_go     <= 1'b1;
                            end
                            PH_WEIGHT: if (first_m) begin
                                phase      <= PH_COMPUTE;  // no partial sums yet
                                comp_start <= 1'b1;
                            end else begin
                                phase     <= PH_OUT_RD;
                                line_addr <= out_start;
                                grp_addr  <= out_start;
                                rd_go     <= 1'b1;
                            end
                            PH_OUT_RD: begin
                                phase      <= PH_COMPUTE;
                                comp_start <= 1'b1;
                            end
                            default: begin
                                phase     <= PH_IDLE;
                                tile_done <= 1'b1;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

//--- logic/conv_sched.sv
`timescale 1ns/1ps

module conv_sched (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic tile_done,
    input  logic last_tile,
    output logic tile_start,
    output logic busy,
    output logic done
);

    logic start_q;
    logic start_edge;

    assign start_edge = start && !start_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q    <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
            tile_start <= 1'b0;
        end else begin
            start_q    <= start;
            done       <= 1'b0;
            tile_start <= 1'b0;
            if (!busy) begin
                if (start_edge) begin  // edges while busy are dropped
                    busy       <= 1'b1;
                    tile_start <= 1'b1;
                end
            end else if (tile_done) begin
                if (last_tile) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    tile_start <= 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/conv_top.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_wr,
    input  logic [2:0]           cfg_addr,
    input  conv_pkg::cfg_word_u  cfg_data,
    input  logic                 start,
    output logic                 busy,
    output logic                 done,
    output logic                 rd_go,
    output conv_pkg::stream_e    rd_strm,
    output logic [`AW-1:0]       rd_base,
    output logic [`AW-1:0]       rd_len,
    input  logic                 rd_done,
    output logic                 wr_go,
    output logic [`AW-1:0]       wr_base,
    output logic [`AW-1:0]       wr_len,
    input  logic                 wr_done,
    output logic                 comp_start,
    output logic [`DIM_W-1:0]    tile_n_size,
    output logic [`DIM_W-1:0]    tile_m_size,
    output logic [`DIM_W-1:0]    tile_row_size,
    output logic [`DIM_W-1:0]    tile_col_size,
    output logic                 first_m,
    input  logic                 comp_done
);

    logic [`DIM_W-1:0] out_n, out_m, in_r, in_c, out_r, out_c;
    logic [`AW-1:0]    in_base, wt_base, out_base;
    logic [`DIM_W-1:0] n_base, m_base, row_base, col_base;
    logic              tile_start, tile_done, last_tile;

    conv_cfg_regs cfg_regs_i (
        .clk(clk), .rst(rst), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .out_n(out_n), .out_m(out_m), .in_r(in_r), .in_c(in_c),
        .out_r(out_r), .out_c(out_c),
        .in_base(in_base), .wt_base(wt_base), .out_base(out_base)
    );

    tile_cord_gen cord_gen_i (
        .clk(clk), .rst(rst), .tile_done(tile_done),
        .out_n(out_n), .out_m(out_m), .out_r(out_r), .out_c(out_c),
        .n_base(n_base), .m_base(m_base), .row_base(row_base), .col_base(col_base),
        .tile_n_size(tile_n_size), .tile_m_size(tile_m_size),
        .tile_row_size(tile_row_size), .tile_col_size(tile_col_size),
        .last_tile(last_tile)
    );

    tile_xfer_gen xfer_gen_i (
        .clk(clk), .rst(rst), .tile_start(tile_start),
        .n_base(n_base), .m_base(m_base), .row_base(row_base), .col_base(col_base),
        .tile_n_size(tile_n_size), .tile_m_size(tile_m_size),
        .tile_row_size(tile_row_size), .tile_col_size(tile_col_size),
        .in_r(in_r), .in_c(in_c), .out_m(out_m), .out_r(out_r), .out_c(out_c),
        .in_base(in_base), .wt_base(wt_base), .out_base(out_base),
        .rd_go(rd_go), .rd_strm(rd_strm), .rd_base(rd_base), .rd_len(rd_len),
        .rd_done(rd_done),
        .wr_go(wr_go), .wr_base(wr_base), .wr_len(wr_len), .wr_done(wr_done),
        .comp_start(comp_start), .first_m(first_m), .comp_done(comp_done),
        .tile_done(tile_done)
    );

    conv_sched sched_i (
        .clk(clk), .rst(rst), .start(start), .tile_done(tile_done),
        .last_tile(last_tile), .tile_start(tile_start), .busy(busy), .done(done)
    );

endmodule

//--- tb/xfer_responder.sv
`timescale 1ns/1ps

module xfer_responder (
    input  logic clk,
    input  logic rst,
    input  logic rd_go,
    input  logic wr_go,
    input  logic comp_start,
    output logic rd_done,
    output logic wr_done,
    output logic comp_done
);

    logic [31:0] rng;
    int          wait_cnt;   // cycles left before the done pulse
    logic [1:0]  pending;    // 0 read, 1 write, 2 compute
    logic        saw_rd;
    logic        saw_wr;
    logic        saw_cp;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    initial begin
        rng       = 32'h746d_1336;
        wait_cnt  = 0;
        pending   = 2'd0;
        rd_done   = 1'b0;
        wr_done   = 1'b0;
        comp_done = 1'b0;
    end

    // one command at a time, so one countdown serves all three ports
    always @(posedge clk) begin
        saw_rd = rd_go;
        saw_wr = wr_go;
        saw_cp = comp_start;
        #1;
        rd_done   = 1'b0;
        wr_done   = 1'b0;
        comp_done = 1'b0;
        if (rst) begin
            wait_cnt = 0;
        end else if (saw_rd || saw_wr || saw_cp) begin
            rng      = xorshift(rng);
            wait_cnt = rng % 6 + 1;  // 1 to 6 cycles
            pending  = saw_wr ? 2'd1 : (saw_cp ? 2'd2 : 2'd0);
        end else if (wait_cnt > 0) begin
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0) begin
                rd_done   = (pending == 2'd0);
                wr_done   = (pending == 2'd1);
                comp_done = (pending == 2'd2);
            end
        end
    end

endmodule

//--- tb/conv_top_tb.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_top_tb;

    localparam int NUM_LAYERS = 3;

    // exact fit, clipped in every dimension, M below one tile
    int          tbl_n  [NUM_LAYERS] = '{4, 6, 3};
    int          tbl_m  [NUM_LAYERS] = '{8, 6, 2};
    int          tbl_r  [NUM_LAYERS] = '{11, 13, 10};
    int          tbl_c  [NUM_LAYERS] = '{13, 15, 9};
    logic [31:0] tbl_ib [NUM_LAYERS] = '{32'h0010_0000, 32'h0020_0000, 32'h0030_0000};
    logic [31:0] tbl_wb [NUM_LAYERS] = '{32'h0040_0000, 32'h0050_0000, 32'h0060_0000};
    logic [31:0] tbl_ob [NUM_LAYERS] = '{32'h0070_0000, 32'h0080_0000, 32'h0090_0000};

    logic clk, rst, cfg_wr, start, busy, done;
    logic [2:0] cfg_addr;
    conv_pkg::cfg_word_u cfg_data;
    logic rd_go, rd_done, wr_go, wr_done, comp_start, comp_done, first_m;
    conv_pkg::stream_e rd_strm;
    logic [`AW-1:0] rd_base, rd_len, wr_base, wr_len;
    logic [`DIM_W-1:0] tile_n_size, tile_m_size, tile_row_size, tile_col_size;

    logic [1:0]  exp_kind [$];  // 0 read, 1 write, 2 compute
    logic [1:0]  exp_strm [$];
    logic [31:0] exp_a    [$];  // base, or packed tile sizes
    logic [31:0] exp_b    [$];  // length, or first_m
    int tiles_cum [NUM_LAYERS];
    int cmds_left [NUM_LAYERS];
    int tiles_built, errors, checks, done_cnt, comp_cnt, cycles, limit;

    conv_top dut_i (
        .clk(clk), .rst(rst), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .start(start), .busy(busy), .done(done),
        .rd_go(rd_go), .rd_strm(rd_strm), .rd_base(rd_base), .rd_len(rd_len),
        .rd_done(rd_done), .wr_go(wr_go), .wr_base(wr_base), .wr_len(wr_len),
        .wr_done(wr_done), .comp_start(comp_start), .tile_n_size(tile_n_size),
        .tile_m_size(tile_m_size), .tile_row_size(tile_row_size),
        .tile_col_size(tile_col_size), .first_m(first_m), .comp_done(comp_done)
    );

    xfer_responder resp_i (
        .clk(clk), .rst(rst), .rd_go(rd_go), .wr_go(wr_go), .comp_start(comp_start),
        .rd_done(rd_done), .wr_done(wr_done), .comp_done(comp_done)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    function automatic int min_int(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    task automatic push_cmd(input logic [1:0] kind, input logic [1:0] strm,
                            input logic [31:0] a, input logic [31:0] b);
        exp_kind.push_back(kind);
        exp_strm.push_back(strm);
        exp_a.push_back(a);
        exp_b.push_back(b);
    endtask

    // expected command stream of one layer, row-major memory
    task automatic build_layer(input int n, input int m, input int r, input int c,
                               input logic [31:0] ib, input logic [31:0] wb,
                               input logic [31:0] ob);
        int ro, co, nb, mb, rb, cb, ns, ms, rs, cs, i, j, in_rows;
        ro = (r - `K) / `S + 1;
        co = (c - `K) / `S + 1;
        for (nb = 0; nb < n; nb += `TN) begin
            for (mb = 0; mb < m; mb += `TM) begin
                for (rb = 0; rb < ro; rb += `TR) begin
                    for (cb = 0; cb < co; cb += `TC) begin
                        ns = min_int(`TN, n - nb);
                        ms = min_int(`TM, m - mb);
                        rs = min_int(`TR, ro - rb);
                        cs = min_int(`TC, co - cb);
                        in_rows = (rs - 1) * `S + `K;  // stride plus kernel halo
                        for (i = 0; i < ms; i++)
                            for (j = 0; j < in_rows; j++)
                                push_cmd(2'd0, conv_pkg::strm_in_fm,
                                         ib + ((mb + i) * r + rb * `S + j) * c + cb * `S,
                                         (cs - 1) * `S + `K);
                        for (i = 0; i < ns; i++)
                            push_cmd(2'd0, conv_pkg::strm_weight,
                                     wb + ((nb + i) * m + mb) * `K * `K, ms * `K * `K);
                        if (mb != 0)  // partial sums only after the first m tile
                            for (i = 0; i < ns; i++)
                                for (j = 0; j < rs; j++)
                                    push_cmd(2'd0, conv_pkg::strm_out_fm,
                                             ob + ((nb + i) * ro + rb + j) * co + cb, cs);
                        push_cmd(2'd2, 2'd0, {8'(ns), 8'(ms), 8'(rs), 8'(cs)}, mb == 0);
                        for (i = 0; i < ns; i++)
                            for (j = 0; j < rs; j++)
                                push_cmd(2'd1, 2'd0, ob + ((nb + i) * ro + rb + j) * co + cb,
                                         cs);
                        tiles_built++;
                    end
                end
            end
        end
    endtask

    task automatic match_cmd(input logic [1:0] kind, input logic [1:0] strm,
                             input logic [31:0] a, input logic [31:0] b,
                             input string name_a, input string name_b);
        if (exp_kind.size() == 0) begin
            errors++;
            $display("t=%0t: %s issued after the expected command list ran out",
                     $time, name_a);
        end else begin
            check_value("command kind", exp_kind.pop_front(), kind);
            if (kind == 2'd0)
                check_value("rd_strm", exp_strm.pop_front(), strm);
            else
                void'(exp_strm.pop_front());
            check_value(name_a, exp_a.pop_front(), a);
            check_value(name_b, exp_b.pop_front(), b);
        end
    endtask

    // go pulses are registered, so mid-cycle sampling sees them settled
    always @(negedge clk) begin
        if (!rst) begin
            if (rd_go)
                match_cmd(2'd0, rd_strm, rd_base, rd_len, "rd_base", "rd_len");
            if (wr_go)
                match_cmd(2'd1, 2'd0, wr_base, wr_len, "wr_base", "wr_len");
            if (comp_start) begin
                comp_cnt++;
                match_cmd(2'd2, 2'd0, {tile_n_size[7:0], tile_m_size[7:0],
                          tile_row_size[7:0], tile_col_size[7:0]}, first_m,
                          "tile sizes", "first_m");
            end
            if (done)
                done_cnt++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, the layer never finished", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic write_reg(input logic [2:0] addr, input conv_pkg::cfg_word_u data);
        @(posedge clk);
        #1;
        cfg_wr   = 1'b1;
        cfg_addr = addr;
        cfg_data = data;
        @(posedge clk);
        #1;
        cfg_wr = 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    task automatic run_layer(input int l);
        conv_pkg::cfg_word_u word;
        int done_before, comp_before;
        word.dims.hi = tbl_n[l];
        word.dims.lo = tbl_m[l];
        write_reg(`CFG_DIMS_NM, word);
        word.dims.hi = tbl_r[l];
        word.dims.lo = tbl_c[l];
        write_reg(`CFG_DIMS_RC, word);
        word.addr = tbl_ib[l];
        write_reg(`CFG_IN_BASE, word);
        word.addr = tbl_wb[l];
        write_reg(`CFG_WT_BASE, word);
        word.addr = tbl_ob[l];
        write_reg(`CFG_OUT_BASE, word);
        done_before = done_cnt;
        comp_before = comp_cnt;
        pulse_start();
        while (comp_cnt == comp_before)
            @(posedge clk);
        check_value("busy", 1, busy);
        // start edges every other cycle for the rest of the layer, all to be ignored
        while (done_cnt == done_before) begin
            @(posedge clk);
            #1 start = busy && !start;
        end
        start = 1'b0;
        check_value("tiles run", tiles_cum[l], comp_cnt);
        check_value("commands left", cmds_left[l], exp_kind.size());
        repeat (20) @(posedge clk);
        check_value("done count", done_before + 1, done_cnt);
        check_value("busy", 0, busy);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cfg_wr = 1'b0;
        cfg_addr = 3'd0;
        cfg_data = '0;
        start = 1'b0;
        for (int l = 0; l < NUM_LAYERS; l++) begin
            build_layer(tbl_n[l], tbl_m[l], tbl_r[l], tbl_c[l], tbl_ib[l], tbl_wb[l],
                        tbl_ob[l]);
            tiles_cum[l] = tiles_built;
            cmds_left[l] = exp_kind.size();
        end
        for (int l = 0; l < NUM_LAYERS; l++)
            cmds_left[l] = exp_kind.size() - cmds_left[l];
        limit = exp_kind.size() * 10 + 200;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        check_value("busy after reset", 0, busy);
        for (int l = 0; l < NUM_LAYERS; l++)
            run_layer(l);
        check_value("commands left", 0, exp_kind.size());
        $display("checks %0d, errors %0d, done pulses %0d", checks, errors, done_cnt);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- src.f
+incdir+logic
logic/conv_pkg.sv
logic/conv_cfg_regs.sv
logic/tile_cord_gen.sv
logic/tile_xfer_gen.sv
logic/conv_sched.sv
logic/conv_top.sv
tb/xfer_responder.sv
tb/conv_top_tb.sv
